// File: fib_bcd_settings.svh
/* Fibonacci BCD calculator settings.
   Datapath widths, the display ceiling and the APB register map. */

`ifndef FIB_BCD_SETTINGS_SVH
`define FIB_BCD_SETTINGS_SVH

`define FIB_BIN_W  16          // width of a binary fibonacci term.
`define FIB_AMT_W  8           // width of the binary count n.
`define FIB_CEIL   16'd9999    // largest value a four digit display can show.

`define APB_ADDR_W 12
`define APB_DATA_W 32

`define REG_CTRL   12'h000     // bit 0 written as one starts a run.
`define REG_AMT    12'h004     // two bcd digits of n in bits 7:0.
`define REG_STATUS 12'h008     // bit 0 ready, bit 1 sticky done.
`define REG_RESULT 12'h00C     // four bcd digits of f(n) in bits 15:0.

`endif

// File: fib_bcd_pkg.sv
/* Shared types of the Fibonacci BCD calculator. */

package fib_bcd_pkg;

    typedef logic [3:0] t_bcd_digit;   // one decimal digit, legal values 0 to 9.

    // One state per stage of the calculation, plus idle.
    typedef enum logic [1:0]
    {
        e_idle,                        // waiting for a start request.
        e_conv_amt,                    // bcd count is being turned into binary.
        e_gen,                         // fibonacci terms are being summed.
        e_conv_res                     // binary result is being turned into bcd.
    } t_ctl_state;

endpackage

// File: bcd_to_bin.sv
/* BCD to binary converter.
   Turns a two digit BCD count into an 8-bit binary count in two cycles. */

`include "fib_bcd_settings.svh"

module bcd_to_bin
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_start,
        input  fib_bcd_pkg::t_bcd_digit i_bcd_tens,
        input  fib_bcd_pkg::t_bcd_digit i_bcd_units,
        output logic o_ready,
        output logic o_done,
        output logic [`FIB_AMT_W-1:0] o_bin
    );

    import fib_bcd_pkg::*;

    logic r_busy;
    logic r_done;
    t_bcd_digit r_units;
    logic [`FIB_AMT_W-1:0] r_bin;
    logic [`FIB_AMT_W-1:0] w_tens_x10;
    logic w_accept;

    assign w_accept = i_start & ~r_busy;
    assign w_tens_x10 = {1'b0, i_bcd_tens, 3'b000} + {3'b000, i_bcd_tens, 1'b0};  // 8t + 2t.

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_busy <= 1'b0;
            r_done <= 1'b0;
        end
        else
        begin
            r_busy <= w_accept;                     // one cycle of multiply, then the add.
            r_done <= r_busy;                       // the add step finishes the run.
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_bin   <= w_tens_x10;
            r_units <= i_bcd_units;
        end
        else if (r_busy)
            r_bin <= r_bin + {4'b0000, r_units};
    end

    assign o_ready = ~r_busy;
    assign o_done  = r_done;
    assign o_bin   = r_bin;

endmodule

// File: fib_operator.sv
/* Iterative Fibonacci generator.
   Sums one term per cycle and saturates at the four digit display ceiling. */

`include "fib_bcd_settings.svh"

module fib_operator
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_start,
        input  logic [`FIB_AMT_W-1:0] i_gen_amt,
        output logic o_ready,
        output logic o_done,
        output logic [`FIB_BIN_W-1:0] o_final
    );

    logic r_busy;
    logic r_done;
    logic [`FIB_AMT_W-1:0] r_cnt;              // additions still to do.
    logic [`FIB_BIN_W-1:0] r_a;                // f(k).
    logic [`FIB_BIN_W-1:0] r_b;                // f(k+1).
    logic [`FIB_BIN_W-1:0] r_final;
    logic [`FIB_BIN_W:0] w_sum;
    logic w_accept;
    logic w_over;
    logic w_last;

    assign w_accept = i_start & ~r_busy;
    assign w_sum    = {1'b0, r_a} + {1'b0, r_b};
    assign w_over   = (w_sum > {1'b0, `FIB_CEIL});
    assign w_last   = (r_cnt == `FIB_AMT_W'(1));

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_busy <= 1'b0;
            r_done <= 1'b0;
            r_cnt  <= '0;
        end
        else
        begin
            r_done <= 1'b0;
            if (w_accept)
            begin
                if (i_gen_amt > `FIB_AMT_W'(1))
                begin
                    r_busy <= 1'b1;
                    r_cnt  <= i_gen_amt - `FIB_AMT_W'(1);  // n-1 additions reach f(n).
                end
                else
                    r_done <= 1'b1;                        // f(0) and f(1) need no loop.
            end
            else if (r_busy)
            begin
                r_cnt <= r_cnt - `FIB_AMT_W'(1);
                if (w_over || w_last)
                begin
                    r_busy <= 1'b0;
                    r_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_a     <= '0;
            r_b     <= `FIB_BIN_W'(1);
            r_final <= `FIB_BIN_W'(i_gen_amt);             // only kept when n is 0 or 1.
        end
        else if (r_busy)
        begin
            r_a <= r_b;
            r_b <= w_sum[`FIB_BIN_W-1:0];
            if (w_over)
                r_final <= `FIB_CEIL;                      // the display cannot show more.
            else if (w_last)
                r_final <= w_sum[`FIB_BIN_W-1:0];
        end
    end

    assign o_ready = ~r_busy;
    assign o_done  = r_done;
    assign o_final = r_final;

endmodule

// File: bin_to_bcd.sv
/* Binary to BCD converter.
   Double dabble over sixteen shifts, giving four BCD digits. */

`include "fib_bcd_settings.svh"

module bin_to_bcd
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_start,
        input  logic [`FIB_BIN_W-1:0] i_bin,
        output logic o_ready,
        output logic o_done,
        output fib_bcd_pkg::t_bcd_digit o_bcd3,
        output fib_bcd_pkg::t_bcd_digit o_bcd2,
        output fib_bcd_pkg::t_bcd_digit o_bcd1,
        output fib_bcd_pkg::t_bcd_digit o_bcd0
    );

    import fib_bcd_pkg::*;

    localparam int CNT_W = $clog2(`FIB_BIN_W) + 1;

    logic r_busy;
    logic r_done;
    logic [CNT_W-1:0] r_cnt;                   // shifts still to do.
    logic [`FIB_BIN_W-1:0] r_shift;            // binary bits not yet shifted in.
    t_bcd_digit [3:0] r_bcd;
    t_bcd_digit [3:0] w_adj;
    logic [`FIB_BIN_W+15:0] w_next;
    logic w_accept;

    assign w_accept = i_start & ~r_busy;
    assign w_next   = {w_adj, r_shift} << 1;

    always_comb
    begin
        for (int i = 0; i < 4; i++)
        begin
            if (r_bcd[i] > 4'd4)
                w_adj[i] = r_bcd[i] + 4'd3;    // the shift then carries into the next digit.
            else
                w_adj[i] = r_bcd[i];
        end
    end

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_busy <= 1'b0;
            r_done <= 1'b0;
            r_cnt  <= '0;
        end
        else
        begin
            r_done <= 1'b0;
            if (w_accept)
            begin
                r_busy <= 1'b1;
                r_cnt  <= CNT_W'(`FIB_BIN_W);
            end
            else if (r_busy)
            begin
                r_cnt <= r_cnt - CNT_W'(1);
                if (r_cnt == CNT_W'(1))
                begin
                    r_busy <= 1'b0;                // last shift, digits are final.
                    r_done <= 1'b1;
                end
            end
        end
    end

    always_ff @(posedge i_clk)
    begin
        if (w_accept)
        begin
            r_shift <= i_bin;
            r_bcd   <= '0;
        end
        else if (r_busy)
        begin
            r_bcd   <= w_next[`FIB_BIN_W+15:`FIB_BIN_W];
            r_shift <= w_next[`FIB_BIN_W-1:0];
        end
    end

    assign o_ready = ~r_busy;
    assign o_done  = r_done;
    assign o_bcd3  = r_bcd[3];
    assign o_bcd2  = r_bcd[2];
    assign o_bcd1  = r_bcd[1];
    assign o_bcd0  = r_bcd[0];

endmodule

// File: fib_ctl.sv
/* Fibonacci BCD controller.
   Chains the count converter, the Fibonacci generator and the result converter. */

`include "fib_bcd_settings.svh"

module fib_ctl
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_start,
        input  fib_bcd_pkg::t_bcd_digit i_gen_amt_tens,
        input  fib_bcd_pkg::t_bcd_digit i_gen_amt_units,
        output logic o_ready,
        output logic o_done,
        output fib_bcd_pkg::t_bcd_digit o_final_bcd3,
        output fib_bcd_pkg::t_bcd_digit o_final_bcd2,
        output fib_bcd_pkg::t_bcd_digit o_final_bcd1,
        output fib_bcd_pkg::t_bcd_digit o_final_bcd0
    );

    import fib_bcd_pkg::*;

    t_ctl_state r_state;
    t_ctl_state w_state_next;

    logic w_b2b_start, w_b2b_ready, w_b2b_done;
    logic w_fib_start, w_fib_ready, w_fib_done;
    logic w_bcd_start, w_bcd_ready, w_bcd_done;
    logic [`FIB_AMT_W-1:0] w_gen_amt_bin;
    logic [`FIB_BIN_W-1:0] w_fib_bin;

    bcd_to_bin u_bcd_to_bin
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_b2b_start),
        .i_bcd_tens(i_gen_amt_tens), .i_bcd_units(i_gen_amt_units),
        .o_ready(w_b2b_ready), .o_done(w_b2b_done),
        .o_bin(w_gen_amt_bin)
    );

    fib_operator u_fib_operator
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_fib_start),
        .i_gen_amt(w_gen_amt_bin),
        .o_ready(w_fib_ready), .o_done(w_fib_done),
        .o_final(w_fib_bin)
    );

    bin_to_bcd u_bin_to_bcd
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_bcd_start),
        .i_bin(w_fib_bin),
        .o_ready(w_bcd_ready), .o_done(w_bcd_done),
        .o_bcd3(o_final_bcd3), .o_bcd2(o_final_bcd2),
        .o_bcd1(o_final_bcd1), .o_bcd0(o_final_bcd0)
    );

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
            r_state <= e_idle;
        else
            r_state <= w_state_next;
    end

    always_comb
    begin
        w_state_next = r_state;
        w_b2b_start  = 1'b0;
        w_fib_start  = 1'b0;
        w_bcd_start  = 1'b0;
        o_ready      = 1'b0;
        o_done       = 1'b0;

        case (r_state)
            e_idle:
            begin
                o_ready = 1'b1;                    // start requests count only here.
                if (i_start && w_b2b_ready)
                begin
                    w_b2b_start  = 1'b1;
                    w_state_next = e_conv_amt;
                end
            end
            e_conv_amt:
            begin
                if (w_b2b_done && w_fib_ready)
                begin
                    w_fib_start  = 1'b1;
                    w_state_next = e_gen;
                end
            end
            e_gen:
            begin
                if (w_fib_done && w_bcd_ready)
                begin
                    w_bcd_start  = 1'b1;
                    w_state_next = e_conv_res;
                end
            end
            e_conv_res:
            begin
                if (w_bcd_done)
                begin
                    o_done       = 1'b1;           // digits are valid in this cycle.
                    w_state_next = e_idle;
                end
            end
            default:
                w_state_next = e_idle;
        endcase
    end

endmodule

// File: fib_apb_regs.sv
/* APB register block of the Fibonacci BCD calculator.
   Holds the count, the start pulse, the status bits and the result. */

`include "fib_bcd_settings.svh"

module fib_apb_regs
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_psel,
        input  logic i_penable,
        input  logic i_pwrite,
        input  logic [`APB_ADDR_W-1:0] i_paddr,
        input  logic [`APB_DATA_W-1:0] i_pwdata,
        output logic [`APB_DATA_W-1:0] o_prdata,
        output logic o_pready,
        output logic o_pslverr,
        output logic o_start,
        output fib_bcd_pkg::t_bcd_digit o_gen_amt_tens,
        output fib_bcd_pkg::t_bcd_digit o_gen_amt_units,
        input  logic i_ready,
        input  logic i_done,
        input  fib_bcd_pkg::t_bcd_digit i_final_bcd3,
        input  fib_bcd_pkg::t_bcd_digit i_final_bcd2,
        input  fib_bcd_pkg::t_bcd_digit i_final_bcd1,
        input  fib_bcd_pkg::t_bcd_digit i_final_bcd0
    );

    import fib_bcd_pkg::*;

    logic w_access;
    logic w_hit;
    logic w_wr;
    logic w_start_wr;
    logic r_start;
    logic r_done;
    t_bcd_digit r_amt_tens;
    t_bcd_digit r_amt_units;
    t_bcd_digit [3:0] r_result;

    assign w_access   = i_psel & i_penable;        // access phase, never stretched.
    assign w_hit      = (i_paddr == `REG_CTRL) | (i_paddr == `REG_AMT) |
                        (i_paddr == `REG_STATUS) | (i_paddr == `REG_RESULT);
    assign w_wr       = w_access & i_pwrite;
    assign w_start_wr = w_wr & (i_paddr == `REG_CTRL) & i_pwdata[0];

    always_ff @(posedge i_clk, posedge i_rst)
    begin
        if (i_rst)
        begin
            r_start     <= 1'b0;
            r_done      <= 1'b0;
            r_amt_tens  <= '0;
            r_amt_units <= '0;
            r_result    <= '0;
        end
        else
        begin
            r_start <= w_start_wr;                 // one cycle pulse after the access.
            if (i_done)
                r_done <= 1'b1;
            else if (w_start_wr)
                r_done <= 1'b0;
            if (w_wr && (i_paddr == `REG_AMT))
            begin
                r_amt_tens  <= i_pwdata[7:4];
                r_amt_units <= i_pwdata[3:0];
            end
            if (i_done)
                r_result <= {i_final_bcd3, i_final_bcd2, i_final_bcd1, i_final_bcd0};
        end
    end

    always_comb
    begin
        case (i_paddr)
            `REG_AMT:    o_prdata = {24'd0, r_amt_tens, r_amt_units};
            `REG_STATUS: o_prdata = {30'd0, r_done, i_ready};
            `REG_RESULT: o_prdata = {16'd0, r_result};
            default:     o_prdata = '0;            // ctrl is write only, unmapped reads zero.
        endcase
    end

    assign o_pready        = 1'b1;
    assign o_pslverr       = w_access & ~w_hit;
    assign o_start         = r_start;
    assign o_gen_amt_tens  = r_amt_tens;
    assign o_gen_amt_units = r_amt_units;

endmodule

// File: fib_bcd_top.sv
/* Fibonacci BCD calculator top level.
   Joins the APB register block to the calculation controller. */

`include "fib_bcd_settings.svh"

module fib_bcd_top
    (
        input  logic i_clk,
        input  logic i_rst,
        input  logic i_psel,
        input  logic i_penable,
        input  logic i_pwrite,
        input  logic [`APB_ADDR_W-1:0] i_paddr,
        input  logic [`APB_DATA_W-1:0] i_pwdata,
        output logic [`APB_DATA_W-1:0] o_prdata,
        output logic o_pready,
        output logic o_pslverr
    );

    import fib_bcd_pkg::*;

    logic w_start, w_ready, w_done;
    t_bcd_digit w_amt_tens, w_amt_units;
    t_bcd_digit w_bcd3, w_bcd2, w_bcd1, w_bcd0;

    fib_apb_regs u_regs
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_psel(i_psel), .i_penable(i_penable), .i_pwrite(i_pwrite),
        .i_paddr(i_paddr), .i_pwdata(i_pwdata),
        .o_prdata(o_prdata), .o_pready(o_pready), .o_pslverr(o_pslverr),
        .o_start(w_start), .o_gen_amt_tens(w_amt_tens), .o_gen_amt_units(w_amt_units),
        .i_ready(w_ready), .i_done(w_done),
        .i_final_bcd3(w_bcd3), .i_final_bcd2(w_bcd2),
        .i_final_bcd1(w_bcd1), .i_final_bcd0(w_bcd0)
    );

    fib_ctl u_ctl
    (
        .i_clk(i_clk), .i_rst(i_rst),
        .i_start(w_start),
        .i_gen_amt_tens(w_amt_tens), .i_gen_amt_units(w_amt_units),
        .o_ready(w_ready), .o_done(w_done),
        .o_final_bcd3(w_bcd3), .o_final_bcd2(w_bcd2),
        .o_final_bcd1(w_bcd1), .o_final_bcd0(w_bcd0)
    );

endmodule

// File: fib_bcd_props.sv
/* Protocol and status properties of the Fibonacci BCD calculator.
   Bound into the top level. */

`include "fib_bcd_settings.svh"

module fib_bcd_props
    (
        input logic i_clk,
        input logic i_rst,
        input logic i_psel,
        input logic i_penable,
        input logic [`APB_ADDR_W-1:0] i_paddr,
        input logic i_pready,
        input logic i_pslverr,
        input logic i_ctl_done,
        input logic i_status_done,
        input logic i_stage_ready,
        input logic i_ctl_ready
    );

    timeunit 1ns;
    timeprecision 100ps;

    int ready_errs = 0;
    int slverr_errs = 0;
    int done_errs = 0;
    int start_errs = 0;
    logic w_mapped;

    assign w_mapped = (i_paddr == `REG_CTRL) || (i_paddr == `REG_AMT) ||
                      (i_paddr == `REG_STATUS) || (i_paddr == `REG_RESULT);

    assert property (@(posedge i_clk) disable iff (i_rst) i_pready)
    else
    begin
        $error("pready went low");
        ready_errs++;
    end

    // the error flag must match an unmapped access phase in both directions.
    assert property (@(posedge i_clk) disable iff (i_rst)
                     i_pslverr == (i_psel && i_penable && !w_mapped))
    else
    begin
        $error("pslverr does not match an unmapped access phase");
        slverr_errs++;
    end

    assert property (@(posedge i_clk) disable iff (i_rst) i_ctl_done |=> i_status_done)
    else
    begin
        $error("status done bit not set after the controller done pulse");
        done_errs++;
    end

    // the count converter drops ready only after taking a start from an idle controller.
    assert property (@(posedge i_clk) disable iff (i_rst)
                     $fell(i_stage_ready) |-> $past(i_ctl_ready))
    else
    begin
        $error("first stage started while the controller was busy");
        start_errs++;
    end

endmodule

bind fib_bcd_top fib_bcd_props u_props
(
    .i_clk(i_clk), .i_rst(i_rst),
    .i_psel(i_psel), .i_penable(i_penable), .i_paddr(i_paddr),
    .i_pready(o_pready), .i_pslverr(o_pslverr),
    .i_ctl_done(w_done), .i_status_done(u_regs.r_done),
    .i_stage_ready(u_ctl.w_b2b_ready), .i_ctl_ready(w_ready)
);

// File: tb_fib_bcd.sv
/* Testbench of the Fibonacci BCD calculator.
   Drives the APB port and checks results against a saturated BCD model. */

`include "fib_bcd_settings.svh"

module tb_fib_bcd;

    timeunit 1ns;
    timeprecision 100ps;

    localparam int MAX_CYCLES = 20000;     // about 25 runs of under 300 cycles each leave margin.
    localparam int POLL_LIMIT = 100;       // status reads of 3 cycles each reach far past a run.

    logic clk, rst, psel, penable, pwrite;
    logic [`APB_ADDR_W-1:0] paddr;
    logic [`APB_DATA_W-1:0] pwdata, prdata;
    logic pready, pslverr;

    int cycle_count = 0;
    int done_pulses = 0;
    int fail_count = 0;
    int tests_passed = 0;
    int tests_failed = 0;
    logic [7:0] lfsr_state = 8'd90;

    fib_bcd_top UUT
    (
        .i_clk(clk), .i_rst(rst),
        .i_psel(psel), .i_penable(penable), .i_pwrite(pwrite),
        .i_paddr(paddr), .i_pwdata(pwdata),
        .o_prdata(prdata), .o_pready(pready), .o_pslverr(pslverr)
    );

    initial
    begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk)
    begin
        cycle_count <= cycle_count + 1;
        if (UUT.w_done)
            done_pulses <= done_pulses + 1;    // completed controller runs.
        if (cycle_count >= MAX_CYCLES)
        begin
            $display("timeout: the run did not finish within %0d cycles", MAX_CYCLES);
            $display("STATUS: FAIL");
            $finish;
        end
    end

    // taps of x^8 + x^6 + x^5 + x^4 + 1 with one step per bit.
    function automatic logic lfsr_bit();
        logic b;
        b = lfsr_state[7];
        lfsr_state = {lfsr_state[6:0],
                      lfsr_state[7] ^ lfsr_state[5] ^ lfsr_state[4] ^ lfsr_state[3]};
        return b;
    endfunction

    function automatic logic [3:0] random_digit();
        logic [3:0] v;
        v = '0;
        for (int i = 0; i < 4; i++)
            v = {v[2:0], lfsr_bit()};
        return (v > 4'd9) ? v - 4'd10 : v;     // fold 10 to 15 onto 0 to 5.
    endfunction

    function automatic logic [15:0] fib_ref_bcd(input int n);
        int a;
        int b;
        int t;
        a = 0;
        b = 1;
        for (int i = 0; i < n; i++)
        begin
            t = a + b;
            a = b;
            b = (t > 10000) ? 10000 : t;       // keeps terms small once past the display.
        end
        if (a > 9999)
            a = 9999;
        return {4'(a / 1000), 4'((a / 100) % 10), 4'((a / 10) % 10), 4'(a % 10)};
    endfunction

    task automatic transfer(input logic wr, input logic [`APB_ADDR_W-1:0] addr,
                            input logic [`APB_DATA_W-1:0] wdata,
                            output logic [`APB_DATA_W-1:0] rdata, output logic err);
        @(posedge clk);
        #2;
        psel   = 1'b1;
        pwrite = wr;
        paddr  = addr;
        pwdata = wdata;
        @(posedge clk);
        #2;
        penable = 1'b1;
        @(negedge clk);
        rdata = prdata;                        // middle of the access phase.
        err   = pslverr;
        if (!pready)
        begin
            $display("pready was low in the access phase to address %h", addr);
            fail_count++;
        end
        @(posedge clk);
        #2;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        assert (act === exp)
        else
        begin
            $display("CHECK FAILED %s expected %h actual %h", name, exp, act);
            fail_count++;
        end
    endtask

    task automatic wait_for_done(input string name);
        logic [31:0] rd;
        logic err;
        int polls;
        logic seen;
        polls = 0;
        seen  = 1'b0;
        while (!seen && polls < POLL_LIMIT)
        begin
            transfer(1'b0, `REG_STATUS, '0, rd, err);
            seen = rd[1];
            polls++;
        end
        if (!seen)
        begin
            $display("%s: done bit never set after %0d status reads", name, POLL_LIMIT);
            fail_count++;
        end
    endtask

    task automatic run_count(input logic [7:0] code);
        logic [31:0] rd;
        logic err;
        logic [15:0] exp;
        string name;
        name = $sformatf("fib(%02h)", code);
        exp  = fib_ref_bcd(int'(code[7:4]) * 10 + int'(code[3:0]));
        transfer(1'b1, `REG_AMT, {24'd0, code}, rd, err);
        transfer(1'b1, `REG_CTRL, 32'd1, rd, err);
        wait_for_done(name);
        transfer(1'b0, `REG_RESULT, '0, rd, err);
        check_value(name, {16'd0, exp}, rd);
    endtask

    task automatic end_test(input string name, input int fails_before);
        if (fail_count == fails_before)
        begin
            tests_passed++;
            $display("test %s ok", name);
        end
        else
        begin
            tests_failed++;
            $display("test %s failed", name);
        end
    endtask

    initial
    begin
        logic [31:0] rd;
        logic err;
        int f0;
        int d0;
        int prop_errs;
        logic [31:0] amt_before, res_before, stat_before;
        logic [3:0] t, u;

        rst     = 1'b1;
        psel    = 1'b0;
        penable = 1'b0;
        pwrite  = 1'b0;
        paddr   = '0;
        pwdata  = '0;
        repeat (4) @(posedge clk);
        #2;
        rst = 1'b0;

        f0 = fail_count;
        transfer(1'b0, `REG_STATUS, '0, rd, err);
        check_value("reset status", 32'h1, rd);
        check_value("reset status pslverr", 32'h0, {31'd0, err});
        transfer(1'b0, `REG_RESULT, '0, rd, err);
        check_value("reset result", 32'h0, rd);
        transfer(1'b0, `REG_AMT, '0, rd, err);
        check_value("reset count", 32'h0, rd);
        end_test("reset values", f0);

        f0 = fail_count;
        run_count(8'h00);
        run_count(8'h01);
        run_count(8'h02);
        run_count(8'h10);
        run_count(8'h19);
        end_test("small counts", f0);

        f0 = fail_count;
        run_count(8'h20);
        run_count(8'h21);
        run_count(8'h50);
        run_count(8'h99);
        end_test("saturation", f0);

        // the second start lands while the first run is still generating.
        f0 = fail_count;
        transfer(1'b1, `REG_AMT, 32'h19, rd, err);
        d0 = done_pulses;
        transfer(1'b1, `REG_CTRL, 32'd1, rd, err);
        transfer(1'b1, `REG_AMT, 32'h05, rd, err);
        transfer(1'b1, `REG_CTRL, 32'd1, rd, err);
        wait_for_done("busy restart");
        transfer(1'b0, `REG_RESULT, '0, rd, err);
        check_value("busy restart result", {16'd0, fib_ref_bcd(19)}, rd);
        repeat (80) @(posedge clk);            // longer than a whole run for n of 05.
        check_value("busy restart done count", 32'd1, 32'(done_pulses - d0));
        end_test("busy restart", f0);

        f0 = fail_count;
        transfer(1'b0, `REG_AMT, '0, amt_before, err);
        transfer(1'b0, `REG_RESULT, '0, res_before, err);
        transfer(1'b0, `REG_STATUS, '0, stat_before, err);
        transfer(1'b1, 12'h010, 32'hFFFF_FFFF, rd, err);
        check_value("unmapped write pslverr", 32'h1, {31'd0, err});
        transfer(1'b0, 12'h010, '0, rd, err);
        check_value("unmapped read data", 32'h0, rd);
        check_value("unmapped read pslverr", 32'h1, {31'd0, err});
        transfer(1'b0, `REG_AMT, '0, rd, err);
        check_value("unmapped count kept", amt_before, rd);
        transfer(1'b0, `REG_RESULT, '0, rd, err);
        check_value("unmapped result kept", res_before, rd);
        transfer(1'b0, `REG_STATUS, '0, rd, err);
        check_value("unmapped status kept", stat_before, rd);
        end_test("unmapped access", f0);

        f0 = fail_count;
        for (int k = 0; k < 12; k++)
        begin
            t = random_digit();
            u = random_digit();
            run_count({t, u});
        end
        end_test("random counts", f0);

        prop_errs = UUT.u_props.ready_errs + UUT.u_props.slverr_errs +
                    UUT.u_props.done_errs + UUT.u_props.start_errs;
        $display("tests passed %0d failed %0d, property failures %0d",
                 tests_passed, tests_failed, prop_errs);
        if (fail_count == 0 && prop_errs == 0)
            $display("STATUS: PASS");
        else
            $display("STATUS: FAIL");
        $finish;
    end

endmodule

// File: fib_bcd.f
+incdir+.
fib_bcd_pkg.sv
bcd_to_bin.sv
fib_operator.sv
bin_to_bcd.sv
fib_ctl.sv
fib_apb_regs.sv
fib_bcd_top.sv
fib_bcd_props.sv
tb_fib_bcd.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Builds the Fibonacci BCD testbench with Verilator, runs it and checks the log.
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing --timescale 1ns/100ps \
    --top-module tb_fib_bcd -f fib_bcd.f -o sim_fib_bcd \
    && ./obj_dir/sim_fib_bcd +verilator+error+limit+100 > sim.log 2>&1
cat sim.log 2>/dev/null
grep -qx "STATUS: PASS" sim.log && echo "simulation passed" && exit 0 \
    || { echo "simulation failed"; exit 1; }
